//--- verilog.f
+incdir+src
src/parser_pkg.sv
src/seg_capture.sv
src/action_table.sv
src/field_extractor.sv
src/phv_builder.sv
src/parser_top.sv
test/tb_clock_gen.sv
test/parser_assertions.sv
test/parser_tb.sv

//--- Bender.yml
package:
  name: parser

sources:
  - include_dirs:
      - src
    files:
      - src/parser_pkg.sv
      - src/seg_capture.sv
      - src/action_table.sv
      - src/field_extractor.sv
      - src/phv_builder.sv
      - src/parser_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_clock_gen.sv
      - test/parser_assertions.sv
      - test/parser_tb.sv

//--- test/parser_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "parser_macros.svh"

module parser_tb;

	localparam int TMO       = 200;                 // cycles allowed per wait
	localparam int PKT_BYTES = 4 * `PRS_KEEP_W;     // longest packet, 4 beats
	localparam int PKT_W     = PKT_BYTES * 8;

	wire                       axis_clk;
	wire                       aresetn;

	logic [`PRS_DATA_W-1:0]    s_tdata;
	logic [`PRS_TUSER_W-1:0]   s_tuser;
	logic [`PRS_KEEP_W-1:0]    s_tkeep;
	logic                      s_tvalid;
	logic                      s_tlast;
	logic                      s_tready;
	logic                      cfg_valid;
	parser_pkg::prof_t         cfg_prof;
	parser_pkg::entry_t        cfg_entry;
	logic                      cfg_ack;
	logic                      phv_valid;
	parser_pkg::phv_t          phv_data;
	logic                      stg_ready;

	int                        n_checks;
	int                        n_errors;
	int                        test_err_base;
	logic [31:0]               lfsr_state;
	parser_pkg::entry_t        model_tbl [1 << `PRS_PROF_W];   // expected table contents

	tb_clock_gen u_clk (
		.o_axis_clk (axis_clk),
		.o_aresetn  (aresetn)
	);

	parser_top u_dut (
		.axis_clk        (axis_clk),
		.aresetn         (aresetn),
		.i_s_axis_tdata  (s_tdata),
		.i_s_axis_tuser  (s_tuser),
		.i_s_axis_tkeep  (s_tkeep),
		.i_s_axis_tvalid (s_tvalid),
		.i_s_axis_tlast  (s_tlast),
		.o_s_axis_tready (s_tready),
		.i_cfg_valid     (cfg_valid),
		.i_cfg_prof      (cfg_prof),
		.i_cfg_entry     (cfg_entry),
		.o_cfg_ack       (cfg_ack),
		.o_phv_valid     (phv_valid),
		.o_phv_data      (phv_data),
		.i_stg_ready     (stg_ready)
	);

	// ==================================================
	// random source and reference model
	// ==================================================
	function automatic logic next_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = (lfsr_state >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
		return out;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], next_bit()};
		end
		return v;
	endfunction

	function automatic logic [PKT_W-1:0] random_bytes();
		logic [PKT_W-1:0] p;
		for (int c = 0; c < PKT_W / 64; c++) begin
			p[c*64 +: 64] = rand_bits(64);
		end
		return p;
	endfunction

	function automatic logic [`PRS_TUSER_W-1:0] random_tuser(input parser_pkg::prof_t prof);
		logic [`PRS_TUSER_W-1:0] t;
		t = {rand_bits(64), rand_bits(64)};
		t[`PRS_PROF_LSB +: `PRS_PROF_W] = prof;
		return t;
	endfunction

	function automatic parser_pkg::action_t make_action(input logic en, input logic [1:0] len,
			input int off);
		parser_pkg::action_t a;
		a = '0;
		a[`PRS_ACT_VALID_BIT] = en;
		a[`PRS_ACT_LEN_LSB +: 2] = len;
		a[`PRS_ACT_OFF_W-1:0] = off[`PRS_ACT_OFF_W-1:0];
		return a;
	endfunction

	// len bytes from offset, first byte most significant
	function automatic parser_pkg::cont_t model_field(input parser_pkg::hdr_t hdr,
			input parser_pkg::action_t act);
		parser_pkg::cont_t v;
		int nbytes;
		int idx;
		v = '0;
		if (act[`PRS_ACT_VALID_BIT]) begin
			nbytes = 1 << act[`PRS_ACT_LEN_LSB +: 2];
			for (int j = 0; j < nbytes; j++) begin
				idx = int'(act[`PRS_ACT_OFF_W-1:0]) + j;
				v = v << 8;
				if (idx < `PRS_HDR_BYTES) begin
					v[7:0] = hdr[8*idx +: 8];
				end
			end
		end
		return v;
	endfunction

	function automatic parser_pkg::phv_t model_phv(input logic [PKT_W-1:0] pkt,
			input int nbytes, input logic [`PRS_TUSER_W-1:0] tuser,
			input parser_pkg::entry_t entry);
		parser_pkg::hdr_t    hdr;
		parser_pkg::phv_t    p;
		parser_pkg::action_t act;
		for (int k = 0; k < `PRS_HDR_BYTES; k++) begin
			hdr[8*k +: 8] = (k < nbytes) ? pkt[8*k +: 8] : 8'h00;   // missing bytes are zero
		end
		p = '0;
		for (int i = 0; i < `PRS_NUM_ACT; i++) begin
			act = entry[i*`PRS_ACT_W +: `PRS_ACT_W];
			p[i*`PRS_CONT_W +: `PRS_CONT_W] = model_field(hdr, act);
			p[`PRS_NUM_ACT*`PRS_CONT_W + i] = act[`PRS_ACT_VALID_BIT];
		end
		p[`PRS_NUM_ACT*`PRS_CONT_W + `PRS_NUM_ACT +: `PRS_TUSER_W] = tuser;
		return p;
	endfunction

	// ==================================================
	// compare tasks and reporting
	// ==================================================
	task automatic compare_phv(input string name, input parser_pkg::phv_t got,
			input parser_pkg::phv_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("error %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_cont(input string name, input parser_pkg::cont_t got,
			input parser_pkg::cont_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("error %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_ack(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("error %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_level(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("error %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		n_errors++;
		$display("timeout: %s never came within %0d cycles", what, TMO);
	endtask

	task automatic start_test();
		test_err_base = n_errors;
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: %s", num, name, (n_errors == test_err_base) ? "ok" : "failed");
	endtask

	// ==================================================
	// stream, config and PHV drivers, all on the falling edge
	// ==================================================
	task automatic send_packet(input logic [PKT_W-1:0] pkt, input int nbytes,
			input logic [`PRS_TUSER_W-1:0] tuser);
		int nbeats;
		int waited;
		nbeats = (nbytes + `PRS_KEEP_W - 1) / `PRS_KEEP_W;
		for (int b = 0; b < nbeats; b++) begin
			s_tdata = pkt[b*`PRS_DATA_W +: `PRS_DATA_W];
			s_tuser = tuser;
			for (int k = 0; k < `PRS_KEEP_W; k++) begin
				s_tkeep[k] = (b * `PRS_KEEP_W + k) < nbytes;
			end
			s_tlast  = (b == nbeats - 1);
			s_tvalid = 1'b1;
			waited   = 0;
			while (!s_tready && waited < TMO) begin   // tready moves on rising edges only
				@(negedge axis_clk);
				waited++;
			end
			if (!s_tready) begin
				report_timeout("o_s_axis_tready");
				break;
			end
			@(negedge axis_clk);
		end
		s_tvalid = 1'b0;
		s_tlast  = 1'b0;
	endtask

	task automatic program_entry(input parser_pkg::prof_t prof, input parser_pkg::entry_t entry);
		int waited;
		cfg_valid = 1'b1;
		cfg_prof  = prof;
		cfg_entry = entry;
		@(negedge axis_clk);
		cfg_valid = 1'b0;
		waited    = 0;
		while (!cfg_ack && waited < TMO) begin
			@(negedge axis_clk);
			waited++;
		end
		if (!cfg_ack) begin
			report_timeout("o_cfg_ack");
		end else begin
			@(negedge axis_clk);
			compare_ack("o_cfg_ack", cfg_ack, 1'b0);   // one cycle pulse
		end
		model_tbl[prof] = entry;
	endtask

	task automatic wait_phv_valid(output logic ok);
		int waited;
		waited = 0;
		while (!phv_valid && waited < TMO) begin
			@(negedge axis_clk);
			waited++;
		end
		ok = phv_valid;
		if (!ok) begin
			report_timeout("o_phv_valid");
		end
	endtask

	// needs stg_ready high, PHV taken on the next rising edge
	task automatic recv_phv(output parser_pkg::phv_t got);
		logic ok;
		wait_phv_valid(ok);
		got = phv_data;
		if (ok) begin
			@(negedge axis_clk);
		end
	endtask

	// ==================================================
	// directed tests
	// ==================================================
	task automatic test_reset();
		logic [PKT_W-1:0]        pkt;
		logic [`PRS_TUSER_W-1:0] tuser;
		parser_pkg::phv_t        got;
		start_test();
		compare_level("o_phv_valid", phv_valid, 1'b0);
		compare_level("o_s_axis_tready", s_tready, 1'b1);
		compare_ack("o_cfg_ack", cfg_ack, 1'b0);
		pkt   = random_bytes();
		tuser = random_tuser(4'hf);   // never programmed
		send_packet(pkt, 64, tuser);
		recv_phv(got);
		compare_phv("o_phv_data", got, model_phv(pkt, 64, tuser, '0));
		end_test(1, "reset and unprogrammed profile");
	endtask

	task automatic test_lengths();
		parser_pkg::entry_t      entry;
		logic [PKT_W-1:0]        pkt;
		logic [`PRS_TUSER_W-1:0] tuser;
		parser_pkg::phv_t        got;
		start_test();
		entry[0*16 +: 16] = make_action(1'b1, 2'd0, 0);
		entry[1*16 +: 16] = make_action(1'b1, 2'd1, 12);
		entry[2*16 +: 16] = make_action(1'b1, 2'd2, 26);
		entry[3*16 +: 16] = make_action(1'b1, 2'd3, 40);
		entry[4*16 +: 16] = make_action(1'b0, 2'd3, 5);    // disabled slot
		entry[5*16 +: 16] = make_action(1'b1, 2'd0, 63);
		entry[6*16 +: 16] = make_action(1'b1, 2'd3, 0);
		entry[7*16 +: 16] = make_action(1'b1, 2'd2, 33);
		program_entry(4'h1, entry);
		pkt   = random_bytes();
		tuser = random_tuser(4'h1);
		send_packet(pkt, 64, tuser);
		recv_phv(got);
		compare_phv("o_phv_data", got, model_phv(pkt, 64, tuser, model_tbl[1]));
		compare_cont("container 4", got[4*`PRS_CONT_W +: `PRS_CONT_W], '0);
		end_test(2, "length codes");
	endtask

	task automatic test_edges();
		parser_pkg::entry_t      entry;
		logic [PKT_W-1:0]        pkt;
		logic [`PRS_TUSER_W-1:0] tuser;
		parser_pkg::phv_t        got;
		int                      lens [3];
		parser_pkg::cont_t       straddle [3];
		parser_pkg::cont_t       tail [3];
		start_test();
		entry = '0;
		entry[0 +: 16]  = make_action(1'b1, 2'd2, 30);   // bytes 30..33 across beats
		entry[16 +: 16] = make_action(1'b1, 2'd3, 60);   // bytes 60..67 past the header
		program_entry(4'h2, entry);
		for (int k = 0; k < PKT_BYTES; k++) begin
			pkt[8*k +: 8] = 8'(k + 1);
		end
		lens     = '{20, 40, 128};
		straddle = '{64'h0, 64'h1f20_2122, 64'h1f20_2122};
		tail     = '{64'h0, 64'h0, 64'h3d3e_3f40_0000_0000};
		for (int t = 0; t < 3; t++) begin
			tuser = random_tuser(4'h2);
			send_packet(pkt, lens[t], tuser);
			recv_phv(got);
			compare_phv("o_phv_data", got, model_phv(pkt, lens[t], tuser, model_tbl[2]));
			compare_cont("container 0", got[0 +: `PRS_CONT_W], straddle[t]);
			compare_cont("container 1", got[`PRS_CONT_W +: `PRS_CONT_W], tail[t]);
		end
		end_test(3, "beat boundary and header end");
	endtask

	task automatic test_backpressure();
		logic [PKT_W-1:0]        pkt_a;
		logic [PKT_W-1:0]        pkt_b;
		logic [`PRS_TUSER_W-1:0] tuser_a;
		logic [`PRS_TUSER_W-1:0] tuser_b;
		parser_pkg::phv_t        held;
		parser_pkg::phv_t        got;
		logic                    ok;
		start_test();
		pkt_a   = random_bytes();
		pkt_b   = random_bytes();
		tuser_a = random_tuser(4'h1);
		tuser_b = random_tuser(4'h2);
		stg_ready = 1'b0;
		send_packet(pkt_a, 64, tuser_a);
		wait_phv_valid(ok);
		held = phv_data;
		compare_phv("o_phv_data", held, model_phv(pkt_a, 64, tuser_a, model_tbl[1]));
		// next packet's first beat sits on the bus
		s_tdata  = pkt_b[`PRS_DATA_W-1:0];
		s_tuser  = tuser_b;
		s_tkeep  = '1;
		s_tlast  = 1'b0;
		s_tvalid = 1'b1;
		repeat (8) begin
			@(negedge axis_clk);
			compare_phv("o_phv_data", phv_data, held);
			compare_level("o_phv_valid", phv_valid, 1'b1);
			compare_level("o_s_axis_tready", s_tready, 1'b0);
		end
		stg_ready = 1'b1;
		send_packet(pkt_b, 96, tuser_b);
		recv_phv(got);
		compare_phv("o_phv_data", got, model_phv(pkt_b, 96, tuser_b, model_tbl[2]));
		end_test(4, "back-pressure");
	endtask

	task automatic test_cfg_collision();
		parser_pkg::entry_t      e_old;
		parser_pkg::entry_t      e_new;
		logic [PKT_W-1:0]        pkt;
		logic [`PRS_TUSER_W-1:0] tuser;
		parser_pkg::phv_t        exp;
		parser_pkg::phv_t        got;
		start_test();
		for (int i = 0; i < `PRS_NUM_ACT; i++) begin
			e_old[i*16 +: 16] = make_action(1'b1, 2'd0, i * 3);
			e_new[i*16 +: 16] = make_action(1'b1, 2'd3, i * 7 + 1);
		end
		program_entry(4'h3, e_old);
		pkt   = random_bytes();
		tuser = random_tuser(4'h3);
		exp   = model_phv(pkt, 64, tuser, e_old);   // lookup wins, old entry
		stg_ready = 1'b0;
		send_packet(pkt, 64, tuser);
		program_entry(4'h3, e_new);   // strobe lands on the lookup cycle
		stg_ready = 1'b1;
		recv_phv(got);
		compare_phv("o_phv_data", got, exp);
		pkt   = random_bytes();
		tuser = random_tuser(4'h3);
		send_packet(pkt, 64, tuser);
		recv_phv(got);
		compare_phv("o_phv_data", got, model_phv(pkt, 64, tuser, e_new));
		end_test(5, "config collision");
	endtask

	task automatic test_random();
		parser_pkg::prof_t       prof;
		logic [PKT_W-1:0]        pkt;
		logic [`PRS_TUSER_W-1:0] tuser;
		parser_pkg::phv_t        got;
		int                      nbytes;
		start_test();
		for (int n = 0; n < 16; n++) begin
			prof = rand_bits(`PRS_PROF_W);
			if (rand_bits(1)) begin
				program_entry(prof, {rand_bits(64), rand_bits(64)});
			end
			nbytes = 1 + int'(rand_bits(7));
			pkt    = random_bytes();
			tuser  = random_tuser(prof);
			send_packet(pkt, nbytes, tuser);
			recv_phv(got);
			compare_phv($sformatf("o_phv_data packet %0d", n), got,
				model_phv(pkt, nbytes, tuser, model_tbl[prof]));
		end
		end_test(6, "random packets");
	endtask

	initial begin
		int waited;
		lfsr_state = 32'hdc0c_e009;
		n_checks   = 0;
		n_errors   = 0;
		s_tdata    = '0;
		s_tuser    = '0;
		s_tkeep    = '0;
		s_tvalid   = 1'b0;
		s_tlast    = 1'b0;
		cfg_valid  = 1'b0;
		cfg_prof   = '0;
		cfg_entry  = '0;
		stg_ready  = 1'b1;
		for (int i = 0; i < (1 << `PRS_PROF_W); i++) begin
			model_tbl[i] = '0;
		end
		waited = 0;
		while (!aresetn && waited < TMO) begin
			@(negedge axis_clk);
			waited++;
		end
		if (!aresetn) begin
			report_timeout("reset release");
		end
		@(negedge axis_clk);
		test_reset();
		test_lengths();
		test_edges();
		test_backpressure();
		test_cfg_collision();
		test_random();
		$display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors,
			u_dut.u_assert.assert_errs);
		if (n_errors == 0 && u_dut.u_assert.assert_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/parser_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module parser_assertions (
	input wire                   axis_clk,
	input wire                   aresetn,
	input wire                   i_phv_valid,
	input wire parser_pkg::phv_t i_phv_data,
	input wire                   i_stg_ready,
	input wire                   i_cfg_valid,
	input wire                   i_cfg_ack
);

	int assert_errs = 0;    // read by the testbench at the end

	// ==================================================
	// PHV output and config acknowledge
	// ==================================================
	a_phv_hold: assert property (@(posedge axis_clk) disable iff (!aresetn)
		i_phv_valid && !i_stg_ready |=> i_phv_valid && $stable(i_phv_data))
	else begin
		assert_errs++;
		$error("PHV changed or dropped while the next stage stalled");
	end

	// write may be deferred one cycle by a lookup
	a_ack_after_cfg: assert property (@(posedge axis_clk) disable iff (!aresetn)
		i_cfg_ack |-> $past(i_cfg_valid) || $past(i_cfg_valid, 2))
	else begin
		assert_errs++;
		$error("config ack without a preceding strobe");
	end

	a_phv_reset: assert property (@(posedge axis_clk) !aresetn |=> !i_phv_valid)
	else begin
		assert_errs++;
		$error("PHV valid high after reset");
	end

endmodule

bind parser_top parser_assertions u_assert (
	.axis_clk    (axis_clk),
	.aresetn     (aresetn),
	.i_phv_valid (o_phv_valid),
	.i_phv_data  (o_phv_data),
	.i_stg_ready (i_stg_ready),
	.i_cfg_valid (i_cfg_valid),
	.i_cfg_ack   (o_cfg_ack)
);

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 16
) (
	output logic o_axis_clk,
	output logic o_aresetn
);

	initial begin
		o_axis_clk = 1'b0;
		forever #(PERIOD / 2) o_axis_clk = ~o_axis_clk;
	end

	// release away from the rising edge
	initial begin
		o_aresetn = 1'b0;
		repeat (RST_CYCLES) @(posedge o_axis_clk);
		@(negedge o_axis_clk);
		o_aresetn = 1'b1;
	end

endmodule

`default_nettype wire

//--- src/parser_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "parser_macros.svh"

module parser_top (
	input  wire                          axis_clk,
	input  wire                          aresetn,

	input  wire [`PRS_DATA_W-1:0]        i_s_axis_tdata,
	input  wire [`PRS_TUSER_W-1:0]       i_s_axis_tuser,
	input  wire [`PRS_KEEP_W-1:0]        i_s_axis_tkeep,
	input  wire                          i_s_axis_tvalid,
	input  wire                          i_s_axis_tlast,
	output wire                          o_s_axis_tready,

	input  wire                          i_cfg_valid,
	input  wire parser_pkg::prof_t       i_cfg_prof,
	input  wire parser_pkg::entry_t      i_cfg_entry,
	output wire                          o_cfg_ack,

	output wire                          o_phv_valid,
	output wire parser_pkg::phv_t        o_phv_data,

	input  wire                          i_stg_ready
);

	wire                                       hdr_valid;
	wire parser_pkg::hdr_t                     hdr;
	wire [`PRS_TUSER_W-1:0]                    hdr_tuser;
	wire parser_pkg::prof_t                    hdr_prof;
	wire                                       hdr_release;

	wire                                       act_valid;
	wire parser_pkg::entry_t                   act_entry;

	wire [`PRS_NUM_ACT-1:0]                    ext_valid;
	wire parser_pkg::cont_t [`PRS_NUM_ACT-1:0] conts;
	wire [`PRS_NUM_ACT-1:0]                    hits;

	seg_capture u_capture (
		.axis_clk        (axis_clk),
		.aresetn         (aresetn),
		.i_s_axis_tdata  (i_s_axis_tdata),
		.i_s_axis_tuser  (i_s_axis_tuser),
		.i_s_axis_tkeep  (i_s_axis_tkeep),
		.i_s_axis_tvalid (i_s_axis_tvalid),
		.i_s_axis_tlast  (i_s_axis_tlast),
		.o_s_axis_tready (o_s_axis_tready),
		.i_hdr_release   (hdr_release),
		.o_hdr_valid     (hdr_valid),
		.o_hdr           (hdr),
		.o_tuser         (hdr_tuser),
		.o_prof          (hdr_prof)
	);

	action_table u_table (
		.axis_clk    (axis_clk),
		.aresetn     (aresetn),
		.i_lookup    (hdr_valid),
		.i_prof      (hdr_prof),
		.i_cfg_valid (i_cfg_valid),
		.i_cfg_prof  (i_cfg_prof),
		.i_cfg_entry (i_cfg_entry),
		.o_cfg_ack   (o_cfg_ack),
		.o_act_valid (act_valid),
		.o_entry     (act_entry)
	);

	// ==================================================
	// one extractor per action slot
	// ==================================================
	for (genvar i = 0; i < `PRS_NUM_ACT; i++) begin : g_ext
		field_extractor u_ext (
			.axis_clk    (axis_clk),
			.aresetn     (aresetn),
			.i_act_valid (act_valid),
			.i_action    (act_entry[i*`PRS_ACT_W +: `PRS_ACT_W]),
			.i_hdr       (hdr),
			.o_valid     (ext_valid[i]),
			.o_cont      (conts[i]),
			.o_hit       (hits[i])
		);
	end

	phv_builder u_phv (
		.axis_clk      (axis_clk),
		.aresetn       (aresetn),
		.i_ext_valid   (&ext_valid),    // all slots move in lockstep
		.i_conts       (conts),
		.i_hits        (hits),
		.i_tuser       (hdr_tuser),
		.i_stg_ready   (i_stg_ready),
		.o_phv_valid   (o_phv_valid),
		.o_phv_data    (o_phv_data),
		.o_hdr_release (hdr_release)
	);

endmodule

`default_nettype wire

//--- src/phv_builder.sv
`timescale 1ns/1ps
`default_nettype none

`include "parser_macros.svh"

module phv_builder (
	input  wire                                         axis_clk,
	input  wire                                         aresetn,

	input  wire                                         i_ext_valid,
	input  wire parser_pkg::cont_t [`PRS_NUM_ACT-1:0]   i_conts,
	input  wire [`PRS_NUM_ACT-1:0]                      i_hits,
	input  wire [`PRS_TUSER_W-1:0]                      i_tuser,

	input  wire                                         i_stg_ready,

	output logic                                        o_phv_valid,
	output parser_pkg::phv_t                            o_phv_data,

	output logic                                        o_hdr_release
);

	logic             phv_accept;
	parser_pkg::phv_t phv_d;

	// ==================================================
	// PHV assembly
	// ==================================================
	// tuser on top, then mask, container 0 lowest
	assign phv_d = {i_tuser, i_hits, i_conts};

	assign phv_accept    = o_phv_valid && i_stg_ready;
	assign o_hdr_release = phv_accept;    // frees the header buffer

	always_ff @(posedge axis_clk) begin
		if (!aresetn) begin
			o_phv_valid <= 1'b0;
		end else begin
			if (i_ext_valid) begin
				o_phv_valid <= 1'b1;
			end else if (phv_accept) begin
				o_phv_valid <= 1'b0;
			end
		end
	end

	// held while the next stage stalls
	always_ff @(posedge axis_clk) begin
		if (i_ext_valid) begin
			o_phv_data <= phv_d;
		end
	end

endmodule

`default_nettype wire

//--- src/field_extractor.sv
`timescale 1ns/1ps
`default_nettype none

`include "parser_macros.svh"

module field_extractor (
	input  wire                          axis_clk,
	input  wire                          aresetn,

	input  wire                          i_act_valid,
	input  wire parser_pkg::action_t     i_action,
	input  wire parser_pkg::hdr_t        i_hdr,

	output logic                         o_valid,
	output parser_pkg::cont_t            o_cont,
	output logic                         o_hit
);

	localparam int WIN_BYTES = `PRS_CONT_W / 8;

	// header padded so a window past byte 63 reads zero
	logic [`PRS_HDR_BYTES*8+`PRS_CONT_W-1:0] hdr_ext;

	logic [`PRS_ACT_OFF_W-1:0]  off;
	logic [1:0]                 len_code;
	logic [3:0]                 nbytes;
	logic                       act_en;

	logic [`PRS_CONT_W-1:0]     win;
	logic [`PRS_CONT_W-1:0]     win_rev;
	parser_pkg::cont_t          cont_d;

	// ==================================================
	// action decode
	// ==================================================
	assign off      = i_action[`PRS_ACT_OFF_W-1:0];
	assign len_code = i_action[`PRS_ACT_LEN_LSB +: 2];
	assign nbytes   = 4'd1 << len_code;    // 1, 2, 4 or 8
	assign act_en   = i_action[`PRS_ACT_VALID_BIT];

	assign hdr_ext = {{`PRS_CONT_W{1'b0}}, i_hdr};
	assign win     = hdr_ext[off*8 +: `PRS_CONT_W];

	// byte j of the window is header byte off+j
	always_comb begin
		for (int j = 0; j < WIN_BYTES; j++) begin
			win_rev[8*(WIN_BYTES-1-j) +: 8] = win[8*j +: 8];
		end
	end

	// first byte ends up most significant, bytes past len shift out
	assign cont_d = win_rev >> (8 * (WIN_BYTES - nbytes));

	always_ff @(posedge axis_clk) begin
		if (!aresetn) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_act_valid;
		end
	end

	always_ff @(posedge axis_clk) begin
		if (i_act_valid) begin
			o_cont <= act_en ? cont_d : '0;
			o_hit  <= act_en;
		end
	end

endmodule

`default_nettype wire

//--- src/action_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "parser_macros.svh"

module action_table (
	input  wire                          axis_clk,
	input  wire                          aresetn,

	input  wire                          i_lookup,
	input  wire parser_pkg::prof_t       i_prof,

	input  wire                          i_cfg_valid,
	input  wire parser_pkg::prof_t       i_cfg_prof,
	input  wire parser_pkg::entry_t      i_cfg_entry,
	output logic                         o_cfg_ack,

	output logic                         o_act_valid,
	output parser_pkg::entry_t           o_entry
);

	localparam int DEPTH = 1 << `PRS_PROF_W;

	parser_pkg::entry_t   mem [DEPTH];
	logic [DEPTH-1:0]     written;     // profile programmed since reset

	// write held back by a lookup
	logic                 pend_valid;
	parser_pkg::prof_t    pend_prof;
	parser_pkg::entry_t   pend_entry;

	logic                 wr_req;
	logic                 wr_grant;
	parser_pkg::prof_t    wr_prof;
	parser_pkg::entry_t   wr_entry;
	parser_pkg::prof_t    port_addr;

	parser_pkg::entry_t   rd_data;
	logic                 rd_hit;

	// ==================================================
	// arbiter, lookup has fixed priority
	// ==================================================
	assign wr_req    = i_cfg_valid || pend_valid;
	assign wr_grant  = wr_req && !i_lookup;
	assign wr_prof   = pend_valid ? pend_prof  : i_cfg_prof;
	assign wr_entry  = pend_valid ? pend_entry : i_cfg_entry;
	assign port_addr = i_lookup ? i_prof : wr_prof;

	always_ff @(posedge axis_clk) begin
		if (!aresetn) begin
			pend_valid  <= 1'b0;
			written     <= '0;
			o_cfg_ack   <= 1'b0;
			o_act_valid <= 1'b0;
		end else begin
			o_act_valid <= i_lookup;
			o_cfg_ack   <= wr_grant;
			if (wr_grant) begin
				pend_valid       <= 1'b0;
				written[wr_prof] <= 1'b1;
			end else if (i_cfg_valid) begin
				pend_valid <= 1'b1;   // lost to a lookup, retry
			end
		end
	end

	always_ff @(posedge axis_clk) begin
		if (i_cfg_valid && !wr_grant) begin
			pend_prof  <= i_cfg_prof;
			pend_entry <= i_cfg_entry;
		end
	end

	// single port memory
	always_ff @(posedge axis_clk) begin
		if (wr_grant) begin
			mem[port_addr] <= wr_entry;
		end else if (i_lookup) begin
			rd_data <= mem[port_addr];
			rd_hit  <= written[port_addr];
		end
	end

	// unprogrammed profiles give no actions
	assign o_entry = rd_hit ? rd_data : '0;

endmodule

`default_nettype wire

//--- src/seg_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "parser_macros.svh"

module seg_capture (
	input  wire                          axis_clk,
	input  wire                          aresetn,

	input  wire [`PRS_DATA_W-1:0]        i_s_axis_tdata,
	input  wire [`PRS_TUSER_W-1:0]       i_s_axis_tuser,
	input  wire [`PRS_KEEP_W-1:0]        i_s_axis_tkeep,
	input  wire                          i_s_axis_tvalid,
	input  wire                          i_s_axis_tlast,
	output logic                         o_s_axis_tready,

	input  wire                          i_hdr_release,

	output logic                         o_hdr_valid,
	output parser_pkg::hdr_t             o_hdr,
	output logic [`PRS_TUSER_W-1:0]      o_tuser,
	output parser_pkg::prof_t            o_prof
);

	localparam int CNT_W = (`PRS_HDR_BEATS > 1) ? $clog2(`PRS_HDR_BEATS) : 1;
	localparam logic ST_HDR   = 1'b0;
	localparam logic ST_DRAIN = 1'b1;

	logic                      state;
	logic [CNT_W-1:0]          beat_cnt;
	logic                      busy;    // header waiting for the PHV stage
	logic                      beat_take;
	logic                      hdr_take;
	logic                      hdr_done;
	logic [`PRS_DATA_W-1:0]    beat_masked;
	parser_pkg::hdr_t          hdr_buf;
	logic [`PRS_TUSER_W-1:0]   tuser_q;

	// new packet waits until the buffer is free
	assign o_s_axis_tready = !(state == ST_HDR && beat_cnt == '0 && busy);

	assign beat_take = i_s_axis_tvalid && o_s_axis_tready;
	assign hdr_take  = beat_take && state == ST_HDR;
	assign hdr_done  = hdr_take &&
		(i_s_axis_tlast || beat_cnt == CNT_W'(`PRS_HDR_BEATS - 1));

	always_comb begin
		for (int k = 0; k < `PRS_KEEP_W; k++) begin
			beat_masked[8*k +: 8] = i_s_axis_tkeep[k] ? i_s_axis_tdata[8*k +: 8] : 8'h00;
		end
	end

	// ==================================================
	// beat counter and header/drain FSM
	// ==================================================
	always_ff @(posedge axis_clk) begin
		if (!aresetn) begin
			state       <= ST_HDR;
			beat_cnt    <= '0;
			busy        <= 1'b0;
			o_hdr_valid <= 1'b0;
		end else begin
			o_hdr_valid <= hdr_done;
			if (hdr_done) begin
				busy <= 1'b1;
			end else if (i_hdr_release) begin
				busy <= 1'b0;
			end

			if (hdr_take) begin
				if (i_s_axis_tlast) begin
					beat_cnt <= '0;       // short packet, all in header
				end else if (hdr_done) begin
					beat_cnt <= '0;
					state    <= ST_DRAIN;
				end else begin
					beat_cnt <= beat_cnt + 1'b1;
				end
			end else if (beat_take && i_s_axis_tlast) begin
				state <= ST_HDR;          // end of payload
			end
		end
	end

	// header buffer, upper beats start out zero
	always_ff @(posedge axis_clk) begin
		if (hdr_take) begin
			if (beat_cnt == '0) begin
				hdr_buf <= '0;
				tuser_q <= i_s_axis_tuser;
			end
			hdr_buf[beat_cnt*`PRS_DATA_W +: `PRS_DATA_W] <= beat_masked;
		end
	end

	assign o_hdr   = hdr_buf;
	assign o_tuser = tuser_q;
	assign o_prof  = tuser_q[`PRS_PROF_LSB +: `PRS_PROF_W];

endmodule

`default_nettype wire

//--- src/parser_pkg.sv
`default_nettype none

`include "parser_macros.svh"

package parser_pkg;

	// captured header, byte 0 in bits 7..0
	typedef logic [`PRS_HDR_BYTES*8-1:0] hdr_t;

	// one parse action
	typedef logic [`PRS_ACT_W-1:0] action_t;

	// all actions of one profile, action i at bits 16i+15..16i
	typedef logic [`PRS_NUM_ACT*`PRS_ACT_W-1:0] entry_t;

	// one extracted field, zero extended
	typedef logic [`PRS_CONT_W-1:0] cont_t;

	typedef logic [`PRS_PROF_W-1:0] prof_t;

	// packet header vector
	// top down: tuser, valid mask, containers 7..0
	typedef logic [
		`PRS_TUSER_W + `PRS_NUM_ACT + `PRS_NUM_ACT*`PRS_CONT_W - 1 : 0
	] phv_t;

endpackage

`default_nettype wire

//--- src/parser_macros.svh
`ifndef PARSER_MACROS_SVH
`define PARSER_MACROS_SVH

`default_nettype none

// ==================================================
// stream geometry
// ==================================================
`define PRS_DATA_W        256
`define PRS_KEEP_W        32
`define PRS_TUSER_W       128

// header capture, first two beats
`define PRS_HDR_BEATS     2
`define PRS_HDR_BYTES     64

// ==================================================
// action table and extractors
// ==================================================
`define PRS_NUM_ACT       8   // actions per profile, one extractor each
`define PRS_ACT_W         16
`define PRS_CONT_W        64
`define PRS_PROF_W        4
`define PRS_PROF_LSB      0   // profile id in first beat tuser

// action word fields
`define PRS_ACT_VALID_BIT 15
`define PRS_ACT_LEN_LSB   13  // 2-bit code, bytes = 1 << code
`define PRS_ACT_OFF_W     6   // byte offset in bits 5..0

`default_nettype wire

`endif
